//--- cr16_macros.svh
`ifndef CR16_MACROS_SVH
`define CR16_MACROS_SVH

// datapath sizes
`define CR16_WIDTH 16
`define CR16_NREGS 16
`define CR16_RADDR 4

////////////////////
// primary opcodes, oper field
`define OP_RR    4'b0000
`define OP_ANDI  4'b0001
`define OP_ORI   4'b0010
`define OP_XORI  4'b0011
`define OP_SCOND 4'b0100
`define OP_ADDI  4'b0101
`define OP_ADDCI 4'b0111
`define OP_SHIFT 4'b1000
`define OP_SUBI  4'b1001
`define OP_CMPI  4'b1011
`define OP_MOVI  4'b1101
`define OP_LUI   4'b1111

// register form function codes
`define FN_AND  4'b0001
`define FN_OR   4'b0010
`define FN_XOR  4'b0011
`define FN_ADD  4'b0101
`define FN_ADDC 4'b0111
`define FN_SUB  4'b1001
`define FN_SUBC 4'b1010
`define FN_CMP  4'b1011
`define FN_MOV  4'b1101
`define FN_MUL  4'b1110

// shift function codes under OP_SHIFT
`define SH_LSHI_L  4'b0000
`define SH_LSHI_R  4'b0001
`define SH_ASHUI_L 4'b0010
`define SH_ASHUI_R 4'b0011
`define SH_LSH     4'b0100
`define SH_ASHU    4'b0110

////////////////////
// condition codes for scond
`define CC_EQ 4'b0000
`define CC_NE 4'b0001
`define CC_CS 4'b0010
`define CC_CC 4'b0011
`define CC_LO 4'b0100
`define CC_HS 4'b0101
`define CC_LT 4'b0110
`define CC_GE 4'b0111
`define CC_FS 4'b1000
`define CC_FC 4'b1001
`define CC_UC 4'b1110

// psr bit positions, carry on top
`define PSR_C 4
`define PSR_L 3
`define PSR_F 2
`define PSR_Z 1
`define PSR_N 0

`endif

//--- cr16Pkg.sv
`include "cr16_macros.svh"

package cr16Pkg;

	////////////////////
	// instruction word views

	// register and shift form
	typedef struct packed {
		logic [3:0] oper;
		logic [3:0] rdst;
		logic [3:0] func;
		logic [3:0] rsrc;
	} rrView;

	// immediate form, imm8 overlays func and rsrc
	typedef struct packed {
		logic [3:0] oper;
		logic [3:0] rdst;
		logic [7:0] imm8;
	} riView;

	// one 16-bit word, decoded either way by oper
	typedef union packed {
		rrView rrForm;
		riView riForm;
	} instrWord;

	////////////////////
	// decoded operations, one per alu behavior
	typedef enum logic [4:0] {
		opAdd, opAddc, opSub, opSubc, opCmp,
		opAnd, opOr, opXor, opMul, opMov,
		opLui, opShl, opShrl, opShra,
		opLshVar, opAshuVar, opScond
	} aluOp;

	// status flags in psr bit order
	typedef struct packed {
		logic c;
		logic l;
		logic f;
		logic z;
		logic n;
	} psrFlags;

	// decoder output toward alu, regfile and psr
	typedef struct packed {
		aluOp                     op;
		logic [`CR16_RADDR-1:0]   rdst;
		logic [`CR16_RADDR-1:0]   rsrc;
		logic [`CR16_WIDTH-1:0]   imm;
		logic                     useImm;
		logic                     regWrite;
		logic [3:0]               cond;
	} decodedInstr;

	// register write, also the writeback report
	typedef struct packed {
		logic [`CR16_RADDR-1:0] addr;
		logic [`CR16_WIDTH-1:0] data;
	} wbBus;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module instrDecoder
	import cr16Pkg::*;
(
	input  instrWord    instr,
	output decodedInstr dec
);

	// both extensions of the 8-bit immediate
	logic [`CR16_WIDTH-1:0] signExt;
	logic [`CR16_WIDTH-1:0] zeroExt;

	assign signExt = {{(`CR16_WIDTH-8){instr.riForm.imm8[7]}}, instr.riForm.imm8};
	assign zeroExt = {{(`CR16_WIDTH-8){1'b0}}, instr.riForm.imm8};

	always_comb begin
		// defaults, a harmless op that writes nothing
		dec          = '0;
		dec.op       = opMov;
		dec.rdst     = instr.rrForm.rdst;
		dec.rsrc     = instr.rrForm.rsrc;
		// scond keeps its condition in the rsrc slot
		dec.cond     = instr.rrForm.rsrc;
		dec.useImm   = 1'b0;
		dec.regWrite = 1'b0;

		case (instr.rrForm.oper)
			////////////////////
			// register form, func picks the op
			`OP_RR: begin
				dec.regWrite = 1'b1;
				case (instr.rrForm.func)
					`FN_AND:  dec.op = opAnd;
					`FN_OR:   dec.op = opOr;
					`FN_XOR:  dec.op = opXor;
					`FN_ADD:  dec.op = opAdd;
					`FN_ADDC: dec.op = opAddc;
					`FN_SUB:  dec.op = opSub;
					`FN_SUBC: dec.op = opSubc;
					`FN_MOV:  dec.op = opMov;
					`FN_MUL:  dec.op = opMul;
					// compare only touches the psr
					`FN_CMP: begin
						dec.op       = opCmp;
						dec.regWrite = 1'b0;
					end
					default:  dec.regWrite = 1'b0;
				endcase
			end

			////////////////////
			// shifts, immediate amount lives in rsrc
			`OP_SHIFT: begin
				dec.regWrite = 1'b1;
				dec.imm      = {{(`CR16_WIDTH-4){1'b0}}, instr.rrForm.rsrc};
				dec.useImm   = 1'b1;
				case (instr.rrForm.func)
					`SH_LSHI_L:  dec.op = opShl;
					`SH_LSHI_R:  dec.op = opShrl;
					`SH_ASHUI_L: dec.op = opShl;
					`SH_ASHUI_R: dec.op = opShra;
					// variable shifts take the amount from register rsrc
					`SH_LSH: begin
						dec.op     = opLshVar;
						dec.useImm = 1'b0;
					end
					`SH_ASHU: begin
						dec.op     = opAshuVar;
						dec.useImm = 1'b0;
					end
					default:     dec.regWrite = 1'b0;
				endcase
			end

			`OP_SCOND: begin
				dec.op       = opScond;
				dec.regWrite = 1'b1;
			end

			////////////////////
			// immediate forms
			default: begin
				dec.useImm   = 1'b1;
				dec.regWrite = 1'b1;
				case (instr.riForm.oper)
					// logic and move immediates are zero extended
					`OP_ANDI:  begin dec.op = opAnd;  dec.imm = zeroExt; end
					`OP_ORI:   begin dec.op = opOr;   dec.imm = zeroExt; end
					`OP_XORI:  begin dec.op = opXor;  dec.imm = zeroExt; end
					`OP_MOVI:  begin dec.op = opMov;  dec.imm = zeroExt; end
					// arithmetic immediates are sign extended
					`OP_ADDI:  begin dec.op = opAdd;  dec.imm = signExt; end
					`OP_ADDCI: begin dec.op = opAddc; dec.imm = signExt; end
					`OP_SUBI:  begin dec.op = opSub;  dec.imm = signExt; end
					`OP_CMPI: begin
						dec.op       = opCmp;
						dec.imm      = signExt;
						dec.regWrite = 1'b0;
					end
					// upper byte only, alu merges the low byte of dst
					`OP_LUI: begin
						dec.op  = opLui;
						dec.imm = {instr.riForm.imm8, 8'h00};
					end
					default: begin
						dec.useImm   = 1'b0;
						dec.regWrite = 1'b0;
					end
				endcase
			end
		endcase
	end

endmodule

//--- regFile.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module regFile
	import cr16Pkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   we,
	input  wbBus                   wr,
	input  logic [`CR16_RADDR-1:0] rdAddrA,
	input  logic [`CR16_RADDR-1:0] rdAddrB,
	output logic [`CR16_WIDTH-1:0] rdDataA,
	output logic [`CR16_WIDTH-1:0] rdDataB,
	output logic                   wbValid,
	output wbBus                   wbOut
);

	// general purpose registers
	logic [`CR16_WIDTH-1:0] regs [`CR16_NREGS];

	// two combinational read ports
	// a write lands at the edge, so the next instruction sees it
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	////////////////////
	// write port
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `CR16_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr.addr] <= wr.data;
		end
	end

	////////////////////
	// writeback report, one cycle after the write

	// strobe, high for one cycle per write
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= we;
		end
	end

	// address and data only meaningful with wbValid
	always_ff @(posedge clk) begin
		if (we) begin
			wbOut <= wr;
		end
	end

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module alu
	import cr16Pkg::*;
(
	input  decodedInstr            dec,
	input  logic [`CR16_WIDTH-1:0] dst,
	input  logic [`CR16_WIDTH-1:0] srcReg,
	input  psrFlags                flagsIn,
	input  logic                   condTrue,
	output logic [`CR16_WIDTH-1:0] result,
	output psrFlags                flagsOut,
	output psrFlags                flagMask
);

	// flags owned by add/sub and by compare
	localparam logic [4:0] ArithMask = (5'b1 << `PSR_C) | (5'b1 << `PSR_F);
	localparam logic [4:0] CmpMask   = (5'b1 << `PSR_L) | (5'b1 << `PSR_Z) | (5'b1 << `PSR_N);

	logic [`CR16_WIDTH-1:0] src;
	logic [`CR16_WIDTH-1:0] addB;
	logic [`CR16_WIDTH:0]   sum;
	logic                   addCin;
	logic                   isSub;
	logic                   overflow;
	logic [4:0]             negAmt;
	logic [`CR16_WIDTH-1:0] varLeft;
	logic [`CR16_WIDTH-1:0] lshRight;
	logic [`CR16_WIDTH-1:0] ashuRight;
	logic [4:0]             flagBits;

	// second operand, register or extended immediate
	assign src = dec.useImm ? dec.imm : srcReg;

	////////////////////
	// shared adder
	// subtract is dst + ~src + 1, borrow input inverts into the carry
	always_comb begin
		isSub  = 1'b0;
		addCin = 1'b0;
		case (dec.op)
			opAddc: addCin = flagsIn.c;
			opSub: begin
				isSub  = 1'b1;
				addCin = 1'b1;
			end
			opSubc: begin
				isSub  = 1'b1;
				addCin = ~flagsIn.c;
			end
			default: ;
		endcase
	end

	assign addB = isSub ? ~src : src;
	assign sum  = {1'b0, dst} + {1'b0, addB} + {{`CR16_WIDTH{1'b0}}, addCin};

	// signed overflow when like-signed operands give the other sign
	assign overflow = (dst[`CR16_WIDTH-1] == addB[`CR16_WIDTH-1])
		&& (sum[`CR16_WIDTH-1] != dst[`CR16_WIDTH-1]);

	////////////////////
	// variable shifts
	// low five bits of src are signed, negative means right by -amt
	assign negAmt    = 5'd0 - src[4:0];
	assign varLeft   = dst << src[3:0];
	assign lshRight  = dst >> negAmt;
	assign ashuRight = $signed(dst) >>> negAmt;

	////////////////////
	// result select
	always_comb begin
		case (dec.op)
			opAdd, opAddc, opSub, opSubc: result = sum[`CR16_WIDTH-1:0];
			opAnd:     result = dst & src;
			opOr:      result = dst | src;
			opXor:     result = dst ^ src;
			// low half of the product
			opMul:     result = dst * src;
			opMov:     result = src;
			// high byte from imm, low byte kept from dst
			opLui:     result = {src[`CR16_WIDTH-1:8], dst[7:0]};
			opShl:     result = dst << src[3:0];
			opShrl:    result = dst >> src[3:0];
			// sign fill
			opShra:    result = $signed(dst) >>> src[3:0];
			opLshVar:  result = src[4] ? lshRight : varLeft;
			opAshuVar: result = src[4] ? ashuRight : varLeft;
			opScond:   result = {{(`CR16_WIDTH-1){1'b0}}, condTrue};
			// cmp writes nothing, result unused
			default:   result = '0;
		endcase
	end

	////////////////////
	// flags and ownership mask
	always_comb begin
		flagBits = '0;
		flagMask = '0;
		case (dec.op)
			opAdd, opAddc, opSub, opSubc: begin
				// carry out for add, borrow for subtract
				flagBits[`PSR_C] = isSub ? ~sum[`CR16_WIDTH] : sum[`CR16_WIDTH];
				flagBits[`PSR_F] = overflow;
				flagMask         = psrFlags'(ArithMask);
			end
			opCmp: begin
				flagBits[`PSR_Z] = (dst == src);
				flagBits[`PSR_L] = (dst < src);
				flagBits[`PSR_N] = ($signed(dst) < $signed(src));
				flagMask         = psrFlags'(CmpMask);
			end
			default: ;
		endcase
		flagsOut = psrFlags'(flagBits);
	end

endmodule

//--- psrUnit.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module psrUnit
	import cr16Pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       update,
	input  psrFlags    flagsNew,
	input  psrFlags    flagMask,
	input  logic [3:0] cond,
	output psrFlags    flags,
	output logic       condTrue
);

	////////////////////
	// status register
	// only the bits the operation owns change, the rest hold
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (update) begin
			flags <= psrFlags'((flags & ~flagMask) | (flagsNew & flagMask));
		end
	end

	////////////////////
	// condition table against the stored psr
	always_comb begin
		case (cond)
			`CC_EQ: condTrue = flags.z;
			`CC_NE: condTrue = ~flags.z;
			`CC_CS: condTrue = flags.c;
			`CC_CC: condTrue = ~flags.c;
			// unsigned lower, from the L flag of cmp
			`CC_LO: condTrue = flags.l;
			`CC_HS: condTrue = ~flags.l;
			// signed less, from N
			`CC_LT: condTrue = flags.n;
			`CC_GE: condTrue = ~flags.n;
			`CC_FS: condTrue = flags.f;
			`CC_FC: condTrue = ~flags.f;
			`CC_UC: condTrue = 1'b1;
			// reserved codes never hold
			default: condTrue = 1'b0;
		endcase
	end

endmodule

//--- cr16Exec.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module cr16Exec
	import cr16Pkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     instrValid,
	input  instrWord instr,
	output logic     wbValid,
	output wbBus     wbOut,
	output psrFlags  psr
);

	decodedInstr            dec;
	logic [`CR16_WIDTH-1:0] dstData;
	logic [`CR16_WIDTH-1:0] srcData;
	logic [`CR16_WIDTH-1:0] result;
	psrFlags                flagsNew;
	psrFlags                flagMask;
	logic                   condTrue;
	wbBus                   wr;

	// decode, fully combinational
	instrDecoder i_decoder (
		.instr (instr),
		.dec   (dec)
	);

	// result always goes back to rdst
	assign wr.addr = dec.rdst;
	assign wr.data = result;

	////////////////////
	// state, written at the accepting edge
	regFile i_regFile (
		.clk     (clk),
		.rstN    (rstN),
		.we      (instrValid & dec.regWrite),
		.wr      (wr),
		.rdAddrA (dec.rdst),
		.rdAddrB (dec.rsrc),
		.rdDataA (dstData),
		.rdDataB (srcData),
		.wbValid (wbValid),
		.wbOut   (wbOut)
	);

	psrUnit i_psrUnit (
		.clk      (clk),
		.rstN     (rstN),
		.update   (instrValid),
		.flagsNew (flagsNew),
		.flagMask (flagMask),
		.cond     (dec.cond),
		.flags    (psr),
		.condTrue (condTrue)
	);

	////////////////////
	// execute
	alu i_alu (
		.dec      (dec),
		.dst      (dstData),
		.srcReg   (srcData),
		.flagsIn  (psr),
		.condTrue (condTrue),
		.result   (result),
		.flagsOut (flagsNew),
		.flagMask (flagMask)
	);

endmodule

//--- tbCr16Exec.sv
`timescale 1ns/1ps
`include "cr16_macros.svh"

module tbCr16Exec
	import cr16Pkg::*;
();

	typedef logic [`CR16_WIDTH-1:0] regArray [`CR16_NREGS];

	// one expected outcome per cycle
	typedef struct packed {
		logic    wbValid;
		wbBus    wb;
		psrFlags psr;
	} expectT;

	localparam int ResetLimit = 20;
	localparam int DrainLimit = 10;

	// operand pairs aimed at carry, borrow and signed overflow
	localparam logic [15:0] ArithA [7] = '{16'h7FFF, 16'hFFFF, 16'h8000, 16'h0000,
		16'h8000, 16'h1234, 16'h0005};
	localparam logic [15:0] ArithB [7] = '{16'h0001, 16'h0001, 16'h0001, 16'h0001,
		16'h8000, 16'h4321, 16'h0005};
	localparam logic [3:0] ArithFns [4] = '{`FN_ADD, `FN_ADDC, `FN_SUB, `FN_SUBC};
	localparam logic [3:0] ArithImms [3] = '{`OP_ADDI, `OP_ADDCI, `OP_SUBI};
	localparam logic [3:0] LogicFns [4] = '{`FN_AND, `FN_OR, `FN_XOR, `FN_MUL};
	localparam logic [3:0] LogicImms [3] = '{`OP_ANDI, `OP_ORI, `OP_XORI};
	localparam logic [3:0] ImmShifts [4] = '{`SH_LSHI_L, `SH_LSHI_R, `SH_ASHUI_L, `SH_ASHUI_R};
	// low five bits are the signed amount, last one has junk above
	localparam logic [15:0] ShAmts [7] = '{16'd3, 16'd15, 16'd0, 16'h001F, 16'h001D,
		16'h0010, 16'hFFE5};

	logic     clk;
	logic     rstN;
	logic     instrValid;
	instrWord instr;
	logic     wbValid;
	wbBus     wbOut;
	psrFlags  psr;

	// model state and expectations in flight
	regArray  modelRegs;
	psrFlags  modelPsr;
	expectT   expQ [$];
	int       errorCount = 0;
	int       timeoutCount = 0;
	int       checkCount = 0;

	cr16Exec i_dut (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbOut      (wbOut),
		.psr        (psr)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	////////////////////
	// instruction encoders
	function automatic logic [15:0] rrWord(input logic [3:0] fn, input logic [3:0] rd,
			input logic [3:0] rs);
		return {`OP_RR, rd, fn, rs};
	endfunction

	function automatic logic [15:0] riWord(input logic [3:0] op, input logic [3:0] rd,
			input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] shiftWord(input logic [3:0] fn, input logic [3:0] rd,
			input logic [3:0] rs);
		return {`OP_SHIFT, rd, fn, rs};
	endfunction

	function automatic logic [15:0] scondWord(input logic [3:0] cond, input logic [3:0] rd);
		return {`OP_SCOND, rd, 4'h0, cond};
	endfunction

	////////////////////
	// reference model
	function automatic logic condHolds(input logic [3:0] cond, input psrFlags p);
		case (cond)
			`CC_EQ: return p.z;
			`CC_NE: return ~p.z;
			`CC_CS: return p.c;
			`CC_CC: return ~p.c;
			`CC_LO: return p.l;
			`CC_HS: return ~p.l;
			`CC_LT: return p.n;
			`CC_GE: return ~p.n;
			`CC_FS: return p.f;
			`CC_FC: return ~p.f;
			`CC_UC: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic expectT predict(input logic [15:0] word, input regArray rf,
			input psrFlags psrIn);
		expectT             e;
		logic [3:0]         rd;
		logic [3:0]         rs;
		logic [15:0]        a;
		logic [15:0]        b;
		logic [15:0]        sImm;
		logic [15:0]        res;
		logic signed [15:0] aS;
		logic               wr;
		logic               arith;
		logic               isSub;
		logic               carryIn;
		logic               cmp;
		int                 sAmt;
		int                 wide;
		int                 sWide;
		rd = word[11:8];
		rs = word[3:0];
		a = rf[rd];
		b = rf[rs];
		aS = a;
		sImm = {{8{word[7]}}, word[7:0]};
		res = '0;
		wr = 1'b1;
		arith = 1'b0;
		isSub = 1'b0;
		carryIn = 1'b0;
		cmp = 1'b0;
		e.psr = psrIn;
		case (word[15:12])
			`OP_RR: begin
				case (word[7:4])
					`FN_AND: res = a & b;
					`FN_OR:  res = a | b;
					`FN_XOR: res = a ^ b;
					`FN_MUL: res = a * b;
					`FN_MOV: res = b;
					`FN_ADD: arith = 1'b1;
					`FN_ADDC: begin
						arith = 1'b1;
						carryIn = psrIn.c;
					end
					`FN_SUB: begin
						arith = 1'b1;
						isSub = 1'b1;
					end
					// carryIn acts as borrow in for subtract
					`FN_SUBC: begin
						arith = 1'b1;
						isSub = 1'b1;
						carryIn = psrIn.c;
					end
					`FN_CMP: begin
						cmp = 1'b1;
						wr = 1'b0;
					end
					default: wr = 1'b0;
				endcase
			end
			// zero extended logic and move immediates
			`OP_ANDI: res = a & {8'h00, word[7:0]};
			`OP_ORI:  res = a | {8'h00, word[7:0]};
			`OP_XORI: res = a ^ {8'h00, word[7:0]};
			`OP_MOVI: res = {8'h00, word[7:0]};
			`OP_LUI:  res = {word[7:0], a[7:0]};
			`OP_ADDI: begin
				arith = 1'b1;
				b = sImm;
			end
			`OP_ADDCI: begin
				arith = 1'b1;
				b = sImm;
				carryIn = psrIn.c;
			end
			`OP_SUBI: begin
				arith = 1'b1;
				isSub = 1'b1;
				b = sImm;
			end
			`OP_CMPI: begin
				cmp = 1'b1;
				wr = 1'b0;
				b = sImm;
			end
			`OP_SCOND: res = {15'h0, condHolds(rs, psrIn)};
			`OP_SHIFT: begin
				sAmt = int'($signed(b[4:0]));
				case (word[7:4])
					`SH_LSHI_L, `SH_ASHUI_L: res = a << rs;
					`SH_LSHI_R:  res = a >> rs;
					`SH_ASHUI_R: res = aS >>> rs;
					`SH_LSH: begin
						if (sAmt < 0) res = a >> (-sAmt);
						else res = a << sAmt;
					end
					// negative amount shifts right with sign fill
					`SH_ASHU: begin
						if (sAmt < 0) res = aS >>> (-sAmt);
						else res = a << sAmt;
					end
					default: wr = 1'b0;
				endcase
			end
			default: wr = 1'b0;
		endcase
		if (arith) begin
			if (isSub) begin
				wide = int'(a) - int'(b) - int'(carryIn);
				sWide = int'($signed(a)) - int'($signed(b)) - int'(carryIn);
				e.psr.c = (wide < 0);
			end else begin
				wide = int'(a) + int'(b) + int'(carryIn);
				sWide = int'($signed(a)) + int'($signed(b)) + int'(carryIn);
				e.psr.c = (wide > 65535);
			end
			res = wide[15:0];
			e.psr.f = (sWide > 32767) || (sWide < -32768);
		end
		if (cmp) begin
			e.psr.z = (a == b);
			e.psr.l = (a < b);
			e.psr.n = ($signed(a) < $signed(b));
		end
		e.wbValid = wr;
		e.wb.addr = wr ? rd : 4'h0;
		e.wb.data = wr ? res : 16'h0;
		return e;
	endfunction

	////////////////////
	// stimulus helpers, drive on the falling edge
	task automatic sendInstr(input logic valid, input logic [15:0] word);
		expectT e;
		@(negedge clk);
		instrValid = valid;
		instr = word;
		if (valid) begin
			e = predict(word, modelRegs, modelPsr);
			if (e.wbValid) modelRegs[e.wb.addr] = e.wb.data;
			modelPsr = e.psr;
		end else begin
			e.wbValid = 1'b0;
			e.wb = '0;
			e.psr = modelPsr;
		end
		expQ.push_back(e);
	endtask

	// movi then lui builds any constant
	task automatic loadReg(input logic [3:0] rd, input logic [15:0] value);
		sendInstr(1'b1, riWord(`OP_MOVI, rd, value[7:0]));
		sendInstr(1'b1, riWord(`OP_LUI, rd, value[15:8]));
	endtask

	task automatic compareOutputs(input expectT want);
		checkCount++;
		if (wbValid !== want.wbValid) begin
			$display("mismatch wbValid: expected %h, got %h", want.wbValid, wbValid);
			errorCount++;
		end
		if (want.wbValid && wbOut.addr !== want.wb.addr) begin
			$display("mismatch wbOut.addr: expected %h, got %h", want.wb.addr, wbOut.addr);
			errorCount++;
		end
		if (want.wbValid && wbOut.data !== want.wb.data) begin
			$display("mismatch wbOut.data: expected %h, got %h", want.wb.data, wbOut.data);
			errorCount++;
		end
		if (psr !== want.psr) begin
			$display("mismatch psr: expected %h, got %h", want.psr, psr);
			errorCount++;
		end
	endtask

	task automatic endRun();
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	////////////////////
	// checker, just after each rising edge
	initial begin : scoreboard
		expectT want;
		int     waited;
		waited = 0;
		while (rstN !== 1'b1 && waited < ResetLimit) begin
			@(posedge clk);
			waited++;
		end
		if (rstN !== 1'b1) begin
			$display("timeout: reset was never released");
			timeoutCount++;
			endRun();
		end else begin
			forever begin
				@(posedge clk);
				#1;
				if (expQ.size() != 0) begin
					want = expQ.pop_front();
					compareOutputs(want);
				end
			end
		end
	end

	////////////////////
	// stimulus
	initial begin : stimulus
		int waited;
		void'($urandom(82184));
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		for (int r = 0; r < `CR16_NREGS; r++) modelRegs[r] = '0;
		modelPsr = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// quiet outputs straight after reset
		@(negedge clk);
		if (wbValid !== 1'b0) begin
			$display("mismatch wbValid after reset: expected 0, got %h", wbValid);
			errorCount++;
		end
		if (psr !== '0) begin
			$display("mismatch psr after reset: expected 00, got %h", psr);
			errorCount++;
		end

		// constants everywhere, then copies
		for (int r = 0; r < 16; r++) loadReg(4'(r), 16'($urandom()));
		for (int r = 0; r < 16; r++) sendInstr(1'b1, rrWord(`FN_MOV, 4'(r), 4'((r + 7) % 16)));
		// idle cycle holds a writing subtract, instrValid low must block it
		sendInstr(1'b0, rrWord(`FN_SUB, 4'd1, 4'd2));

		// add and subtract, register and immediate
		for (int i = 0; i < 7; i++) begin
			for (int f = 0; f < 4; f++) begin
				loadReg(4'd5, ArithA[i]);
				loadReg(4'd6, ArithB[i]);
				sendInstr(1'b1, rrWord(ArithFns[f], 4'd5, 4'd6));
			end
			for (int f = 0; f < 3; f++) begin
				loadReg(4'd5, ArithA[i]);
				sendInstr(1'b1, riWord(ArithImms[f], 4'd5, ArithB[i][7:0]));
				loadReg(4'd5, ArithA[i]);
				sendInstr(1'b1, riWord(ArithImms[f], 4'd5, 8'h80));
			end
		end

		// logic ops and multiply leave psr alone
		for (int i = 0; i < 7; i++) begin
			for (int f = 0; f < 4; f++) begin
				loadReg(4'd7, ArithA[i]);
				loadReg(4'd8, ArithB[i] ^ 16'h0F3C);
				sendInstr(1'b1, rrWord(LogicFns[f], 4'd7, 4'd8));
			end
			for (int f = 0; f < 3; f++) begin
				loadReg(4'd7, ArithA[i] ^ 16'hA5C3);
				sendInstr(1'b1, riWord(LogicImms[f], 4'd7, 8'hF0));
			end
		end

		// variable and immediate shifts on a negative value
		for (int i = 0; i < 7; i++) begin
			loadReg(4'd9, 16'hB6D1);
			loadReg(4'd10, ShAmts[i]);
			sendInstr(1'b1, shiftWord(`SH_LSH, 4'd9, 4'd10));
			loadReg(4'd9, 16'hB6D1);
			sendInstr(1'b1, shiftWord(`SH_ASHU, 4'd9, 4'd10));
		end
		for (int amt = 0; amt < 16; amt += 5) begin
			for (int f = 0; f < 4; f++) begin
				loadReg(4'd9, 16'hB6D1);
				sendInstr(1'b1, shiftWord(ImmShifts[f], 4'd9, 4'(amt)));
			end
		end
		sendInstr(1'b0, rrWord(`FN_SUB, 4'd1, 4'd2));

		// compare both ways, then every condition code
		for (int i = 0; i < 7; i++) begin
			loadReg(4'd12, ArithA[i]);
			loadReg(4'd13, ArithB[i]);
			sendInstr(1'b1, rrWord(`FN_CMP, 4'd12, 4'd13));
			for (int c = 0; c < 16; c++) sendInstr(1'b1, scondWord(4'(c), 4'(c)));
			loadReg(4'd12, ArithA[i]);
			loadReg(4'd13, ArithB[i]);
			sendInstr(1'b1, rrWord(`FN_CMP, 4'd13, 4'd12));
			for (int c = 0; c < 16; c++) sendInstr(1'b1, scondWord(4'(c), 4'(c)));
			loadReg(4'd12, ArithA[i]);
			sendInstr(1'b1, riWord(`OP_CMPI, 4'd12, ArithB[i][7:0]));
			for (int c = 0; c < 16; c++) sendInstr(1'b1, scondWord(4'(c), 4'(c)));
		end

		// random back to back words, unknown opcodes included
		for (int i = 0; i < 2000; i++) sendInstr(1'b1, 16'($urandom()));
		sendInstr(1'b0, rrWord(`FN_SUB, 4'd1, 4'd2));

		// let the checker drain the queue
		waited = 0;
		while (expQ.size() != 0 && waited < DrainLimit) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d expected results were never checked", expQ.size());
			timeoutCount++;
		end
		endRun();
	end

endmodule

//--- all.f
+incdir+.
cr16Pkg.sv
instrDecoder.sv
regFile.sv
alu.sv
psrUnit.sv
cr16Exec.sv
tbCr16Exec.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tbCr16Exec -Mdir obj_dir -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi
